// ==== source/div_op_pkg.sv ====
// divide unit operation encoding and iteration state machine states
`default_nettype none

package div_op_pkg;

  // ==========================================================================
  // operation codes
  // ==========================================================================

  // one-hot, DIV at bit 7 down to REMW at bit 0
  typedef logic [7:0] div_op_t;

  localparam div_op_t OP_DIV   = 8'b1000_0000; // signed, 64-bit quotient
  localparam div_op_t OP_DIVU  = 8'b0100_0000; // unsigned, 64-bit quotient
  localparam div_op_t OP_DIVUW = 8'b0010_0000; // unsigned, 32-bit quotient
  localparam div_op_t OP_DIVW  = 8'b0001_0000; // signed, 32-bit quotient
  localparam div_op_t OP_REM   = 8'b0000_1000; // signed, 64-bit remainder
  localparam div_op_t OP_REMU  = 8'b0000_0100; // unsigned, 64-bit remainder
  localparam div_op_t OP_REMUW = 8'b0000_0010; // unsigned, 32-bit remainder
  localparam div_op_t OP_REMW  = 8'b0000_0001; // signed, 32-bit remainder

  // ==========================================================================
  // iteration state machine
  // ==========================================================================

  // ST_IDLE   waits for a start
  // ST_ITER   one quotient bit per cycle until the count reaches zero
  // ST_FINISH holds the result until the consumer is ready
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ITER   = 2'd1,
    ST_FINISH = 2'd2
  } div_state_e;

endpackage : div_op_pkg

`default_nettype wire

// ==== source/div_data_pkg.sv ====
// divide unit data widths and special result constants
`default_nettype none

package div_data_pkg;

  // ==========================================================================
  // data widths
  // ==========================================================================

  typedef logic [63:0]  xlen_t;     // register word
  typedef logic [127:0] dword_t;    // remainder:quotient shift register
  typedef logic [6:0]   iter_cnt_t; // remaining iterations, 0..64

  // ==========================================================================
  // special values
  // ==========================================================================

  // quotient of a divide by zero, also -1 as a divisor
  localparam xlen_t ALL_ONES   = {64{1'b1}};

  // most negative value, dividend side of the overflow case
  localparam xlen_t MIN_SIGNED = {1'b1, 63'b0};

endpackage : div_data_pkg

`default_nettype wire

// ==== source/div_prep.sv ====
// divide operand preparation: absolute values, signs, iteration count, exceptions
`timescale 1ns/1ps
`default_nettype none

module div_prep (
  input  div_op_pkg::div_op_t       op_i,
  input  div_data_pkg::xlen_t       dividend_i,
  input  div_data_pkg::xlen_t       divisor_i,
  output div_data_pkg::xlen_t       abs_dividend_o,
  output div_data_pkg::xlen_t       abs_divisor_o,
  output div_data_pkg::iter_cnt_t   iter_count_o,
  output logic                      quot_neg_o,
  output logic                      rem_neg_o,
  output logic                      exc_hit_o,
  output div_data_pkg::xlen_t       exc_result_o
);

  // ==========================================================================
  // operation class
  // ==========================================================================

  logic is_signed;
  logic is_w;
  logic is_rem;

  assign is_signed = |(op_i & (div_op_pkg::OP_DIV | div_op_pkg::OP_DIVW |
                               div_op_pkg::OP_REM | div_op_pkg::OP_REMW));
  assign is_w      = |(op_i & (div_op_pkg::OP_DIVUW | div_op_pkg::OP_DIVW |
                               div_op_pkg::OP_REMUW | div_op_pkg::OP_REMW));
  assign is_rem    = |(op_i & (div_op_pkg::OP_REM   | div_op_pkg::OP_REMU |
                               div_op_pkg::OP_REMUW | div_op_pkg::OP_REMW));

  // ==========================================================================
  // operand extension and absolute values
  // ==========================================================================

  div_data_pkg::xlen_t dvd_sext32;
  div_data_pkg::xlen_t dvs_sext32;
  div_data_pkg::xlen_t dvd_ext;
  div_data_pkg::xlen_t dvs_ext;
  div_data_pkg::xlen_t dvd_abs;
  div_data_pkg::xlen_t dvs_abs;
  logic                dvd_neg;
  logic                dvs_neg;

  assign dvd_sext32 = {{32{dividend_i[31]}}, dividend_i[31:0]};
  assign dvs_sext32 = {{32{divisor_i[31]}}, divisor_i[31:0]};

  // W forms only look at the low word
  assign dvd_ext = !is_w     ? dividend_i :
                   is_signed ? dvd_sext32 : {32'b0, dividend_i[31:0]};
  assign dvs_ext = !is_w     ? divisor_i  :
                   is_signed ? dvs_sext32 : {32'b0, divisor_i[31:0]};

  assign dvd_neg = is_signed & dvd_ext[63];
  assign dvs_neg = is_signed & dvs_ext[63];

  assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
  assign dvs_abs = dvs_neg ? -dvs_ext : dvs_ext;

  // W dividend sits in the upper word so 32 shifts are enough
  assign abs_dividend_o = is_w ? {dvd_abs[31:0], 32'b0} : dvd_abs;
  assign abs_divisor_o  = dvs_abs;
  assign iter_count_o   = is_w ? 7'd32 : 7'd64;

  assign quot_neg_o = dvd_neg ^ dvs_neg;
  assign rem_neg_o  = dvd_neg;             // remainder follows the dividend

  // ==========================================================================
  // divide by zero and signed overflow
  // ==========================================================================

  logic                div_zero;
  logic                overflow;
  div_data_pkg::xlen_t dvd_res;

  assign div_zero = is_w ? (divisor_i[31:0] == 32'b0) : (divisor_i == '0);

  assign overflow = is_signed & (is_w ?
      ((dividend_i[31:0] == div_data_pkg::MIN_SIGNED[63:32]) &&
       (divisor_i[31:0] == div_data_pkg::ALL_ONES[31:0])) :
      ((dividend_i == div_data_pkg::MIN_SIGNED) &&
       (divisor_i == div_data_pkg::ALL_ONES)));

  assign dvd_res = is_w ? dvd_sext32 : dividend_i; // dividend as a result word

  assign exc_hit_o = div_zero | overflow;

  always_comb begin
    exc_result_o = '0;
    if (div_zero) begin
      exc_result_o = is_rem ? dvd_res : div_data_pkg::ALL_ONES;
    end else if (overflow) begin
      exc_result_o = is_rem ? '0 : dvd_res;  // quotient wraps to the dividend
    end
  end

endmodule : div_prep

`default_nettype wire

// ==== source/div_core.sv ====
// divide core: restoring shift/subtract iteration, counter and result hold
`timescale 1ns/1ps
`default_nettype none

module div_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  div_op_pkg::div_op_t       op_i,
  input  div_data_pkg::xlen_t       abs_dividend_i,
  input  div_data_pkg::xlen_t       abs_divisor_i,
  input  div_data_pkg::iter_cnt_t   iter_count_i,
  input  logic                      quot_neg_i,
  input  logic                      rem_neg_i,
  input  logic                      exc_hit_i,
  input  div_data_pkg::xlen_t       exc_result_i,
  input  logic                      result_ready_i,
  output logic                      busy_o,
  output logic                      result_valid_o,
  output div_data_pkg::xlen_t       quot_o,
  output div_data_pkg::xlen_t       rem_o,
  output div_op_pkg::div_op_t       op_o,
  output logic                      quot_neg_o,
  output logic                      rem_neg_o,
  output logic                      exc_o,
  output div_data_pkg::xlen_t       exc_result_o
);

  div_op_pkg::div_state_e  state_q;
  div_data_pkg::iter_cnt_t cnt_q;
  div_data_pkg::dword_t    acc_q;         // remainder:quotient
  div_data_pkg::xlen_t     dvs_q;
  div_op_pkg::div_op_t     op_q;
  logic                    quot_neg_q;
  logic                    rem_neg_q;
  logic                    exc_q;
  div_data_pkg::xlen_t     exc_result_q;

  logic                    accept;
  logic                    iter_step;

  assign accept    = (state_q == div_op_pkg::ST_IDLE) && start_i;
  assign iter_step = (state_q == div_op_pkg::ST_ITER) && (cnt_q != '0);

  // ==========================================================================
  // restoring step
  // ==========================================================================

  logic [64:0]          partial;   // 2*rem plus next dividend bit
  logic [65:0]          diff;
  logic                 borrow;
  div_data_pkg::dword_t acc_next;

  assign partial = acc_q[127:63];
  assign diff    = {1'b0, partial} - {2'b00, dvs_q};
  assign borrow  = diff[65];

  // on borrow partial < divisor, so bit 127 is zero and the plain shift holds
  assign acc_next = borrow ? {acc_q[126:0], 1'b0}
                           : {diff[63:0], acc_q[62:0], 1'b1};

  // ==========================================================================
  // state machine
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_op_pkg::ST_IDLE;
      cnt_q   <= '0;
      op_q    <= '0;
      exc_q   <= 1'b0;
    end else begin
      case (state_q)
        div_op_pkg::ST_IDLE: begin
          if (start_i) begin
            op_q  <= op_i;
            exc_q <= exc_hit_i;
            if (exc_hit_i) begin
              state_q <= div_op_pkg::ST_FINISH; // no iteration needed
              cnt_q   <= '0;
            end else begin
              state_q <= div_op_pkg::ST_ITER;
              cnt_q   <= iter_count_i;
            end
          end
        end
        div_op_pkg::ST_ITER: begin
          if (cnt_q == '0) begin
            state_q <= div_op_pkg::ST_FINISH;
          end else begin
            cnt_q <= cnt_q - 7'd1;
          end
        end
        div_op_pkg::ST_FINISH: begin
          if (result_ready_i) begin
            state_q <= div_op_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= div_op_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // operands and sign flags, loaded once per operation
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q        <= {64'b0, abs_dividend_i};
      dvs_q        <= abs_divisor_i;
      quot_neg_q   <= quot_neg_i;
      rem_neg_q    <= rem_neg_i;
      exc_result_q <= exc_result_i;
    end else if (iter_step) begin
      acc_q <= acc_next;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================

  assign busy_o         = accept | (state_q == div_op_pkg::ST_ITER);
  assign result_valid_o = (state_q == div_op_pkg::ST_FINISH);

  assign quot_o       = acc_q[63:0];
  assign rem_o        = acc_q[127:64];
  assign op_o         = op_q;
  assign quot_neg_o   = quot_neg_q;
  assign rem_neg_o    = rem_neg_q;
  assign exc_o        = exc_q;
  assign exc_result_o = exc_result_q;

  // ==========================================================================
  // assertions
  // ==========================================================================

  // decoder in div_prep relies on a single op bit
  a_onehot_op : assert property (@(posedge clk) disable iff (rst_n)
    accept |-> $onehot(op_i));

  a_cnt_range : assert property (@(posedge clk) disable iff (rst_n)
    cnt_q <= 7'd64);

  // stall and result hand-off are exclusive phases
  a_busy_valid : assert property (@(posedge clk) disable iff (rst_n)
    !(result_valid_o && busy_o));

endmodule : div_core

`default_nettype wire

// ==== source/div_post.sv ====
// divide result finishing: sign fix, quotient/remainder select, W sign extension
`timescale 1ns/1ps
`default_nettype none

module div_post (
  input  div_op_pkg::div_op_t   op_i,
  input  div_data_pkg::xlen_t   quot_i,
  input  div_data_pkg::xlen_t   rem_i,
  input  logic                  quot_neg_i,
  input  logic                  rem_neg_i,
  input  logic                  exc_i,
  input  div_data_pkg::xlen_t   exc_result_i,
  input  logic                  valid_i,
  output div_data_pkg::xlen_t   result_o
);

  logic                is_w;
  logic                is_rem;
  div_data_pkg::xlen_t quot_fix;
  div_data_pkg::xlen_t rem_fix;
  div_data_pkg::xlen_t sel;
  div_data_pkg::xlen_t finished;

  assign is_w   = |(op_i & (div_op_pkg::OP_DIVUW | div_op_pkg::OP_DIVW |
                            div_op_pkg::OP_REMUW | div_op_pkg::OP_REMW));
  assign is_rem = |(op_i & (div_op_pkg::OP_REM   | div_op_pkg::OP_REMU |
                            div_op_pkg::OP_REMUW | div_op_pkg::OP_REMW));

  // core works on magnitudes
  assign quot_fix = quot_neg_i ? -quot_i : quot_i;
  assign rem_fix  = rem_neg_i  ? -rem_i  : rem_i;

  assign sel = is_rem ? rem_fix : quot_fix;

  always_comb begin
    if (exc_i) begin
      finished = exc_result_i;                     // already sign-extended
    end else if (is_w) begin
      finished = {{32{sel[31]}}, sel[31:0]};
    end else begin
      finished = sel;
    end
  end

  assign result_o = valid_i ? finished : '0;      // zero outside the hand-off

endmodule : div_post

`default_nettype wire

// ==== source/div_unit.sv ====
// RV64M integer divide unit: operand prep, iterative core and result finishing
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  div_op_pkg::div_op_t   op_i,
  input  div_data_pkg::xlen_t   dividend_i,
  input  div_data_pkg::xlen_t   divisor_i,
  input  logic                  result_ready_i,
  output div_data_pkg::xlen_t   result_o,
  output logic                  busy_o,
  output logic                  result_valid_o
);

  // ==========================================================================
  // prep to core
  // ==========================================================================

  div_data_pkg::xlen_t     abs_dividend;
  div_data_pkg::xlen_t     abs_divisor;
  div_data_pkg::iter_cnt_t iter_count;
  logic                    quot_neg;
  logic                    rem_neg;
  logic                    exc_hit;
  div_data_pkg::xlen_t     exc_result;

  // ==========================================================================
  // core to post
  // ==========================================================================

  div_data_pkg::xlen_t     core_quot;
  div_data_pkg::xlen_t     core_rem;
  div_op_pkg::div_op_t     core_op;
  logic                    core_quot_neg;
  logic                    core_rem_neg;
  logic                    core_exc;
  div_data_pkg::xlen_t     core_exc_result;

  div_prep i_prep (
    .op_i           (op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .abs_dividend_o (abs_dividend),
    .abs_divisor_o  (abs_divisor),
    .iter_count_o   (iter_count),
    .quot_neg_o     (quot_neg),
    .rem_neg_o      (rem_neg),
    .exc_hit_o      (exc_hit),
    .exc_result_o   (exc_result)
  );

  div_core i_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .op_i           (op_i),
    .abs_dividend_i (abs_dividend),
    .abs_divisor_i  (abs_divisor),
    .iter_count_i   (iter_count),
    .quot_neg_i     (quot_neg),
    .rem_neg_i      (rem_neg),
    .exc_hit_i      (exc_hit),
    .exc_result_i   (exc_result),
    .result_ready_i (result_ready_i),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .quot_o         (core_quot),
    .rem_o          (core_rem),
    .op_o           (core_op),
    .quot_neg_o     (core_quot_neg),
    .rem_neg_o      (core_rem_neg),
    .exc_o          (core_exc),
    .exc_result_o   (core_exc_result)
  );

  div_post i_post (
    .op_i         (core_op),
    .quot_i       (core_quot),
    .rem_i        (core_rem),
    .quot_neg_i   (core_quot_neg),
    .rem_neg_i    (core_rem_neg),
    .exc_i        (core_exc),
    .exc_result_i (core_exc_result),
    .valid_i      (result_valid_o),
    .result_o     (result_o)
  );

endmodule : div_unit

`default_nettype wire

// ==== verification/tb_div_unit.sv ====
// directed testbench for the RV64M divide unit with reference model and LFSR operands
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

  localparam int NUM_RANDOM     = 300;
  localparam int NUM_OPS        = 56 + 32 + 8 + 1 + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 70 + 500;   // worst op is about 68 cycles
  localparam int VALID_LIMIT    = 200;

  logic                clk;
  logic                rst_n;
  logic                start_i;
  div_op_pkg::div_op_t op_i;
  div_data_pkg::xlen_t dividend_i;
  div_data_pkg::xlen_t divisor_i;
  logic                result_ready_i;
  div_data_pkg::xlen_t result_o;
  logic                busy_o;
  logic                result_valid_o;

  int          error_cnt;
  int          check_cnt;
  int          cycle_cnt;
  logic [31:0] lfsr_q;

  div_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .op_i           (op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o)
  );

  always #50 clk = ~clk;                                 // 100 ns period

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================

  task automatic check_result(input string what, input div_data_pkg::xlen_t got,
                              input div_data_pkg::xlen_t expect_v);
    check_cnt++;
    if (got !== expect_v) begin
      error_cnt++;
      $display("** Error at time %0t: %s: result %h, expected %h", $time, what, got, expect_v);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic expect_v);
    check_cnt++;
    if (got !== expect_v) begin
      error_cnt++;
      $display("** Error at time %0t: %s: level %b, expected %b", $time, what, got, expect_v);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int expect_v);
    check_cnt++;
    if (got != expect_v) begin
      error_cnt++;
      $display("** Error at time %0t: %s: %0d cycles, expected %0d", $time, what, got, expect_v);
    end
  endtask

  // ==========================================================================
  // reference model and stimulus helpers
  // ==========================================================================

  function automatic div_data_pkg::xlen_t sign_extend_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic div_data_pkg::xlen_t expected_result(input div_op_pkg::div_op_t op,
      input div_data_pkg::xlen_t a, input div_data_pkg::xlen_t b);
    logic signed [63:0] sa, sb, sq64, sr64;
    logic signed [31:0] sa32, sb32, sq32, sr32;
    logic [63:0]        uq64, ur64;
    logic [31:0]        uq32, ur32;
    logic               uz64, uz32, ov64, ov32;
    div_data_pkg::xlen_t r;
    sa   = a;
    sb   = b;
    sa32 = a[31:0];
    sb32 = b[31:0];
    uz64 = (b == 64'd0);
    uz32 = (b[31:0] == 32'd0);
    ov64 = (a == 64'h8000_0000_0000_0000) && (b == {64{1'b1}});
    ov32 = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
    {sq64, sr64, uq64, ur64} = '0;
    {sq32, sr32, uq32, ur32} = '0;
    if (!uz64 && !ov64) begin
      sq64 = sa / sb;
      sr64 = sa % sb;
    end
    if (!uz32 && !ov32) begin
      sq32 = sa32 / sb32;
      sr32 = sa32 % sb32;
    end
    if (!uz64) begin
      uq64 = a / b;
      ur64 = a % b;
    end
    if (!uz32) begin
      uq32 = a[31:0] / b[31:0];
      ur32 = a[31:0] % b[31:0];
    end
    case (op)
      div_op_pkg::OP_DIV:   r = uz64 ? {64{1'b1}} : ov64 ? a : sq64;
      div_op_pkg::OP_DIVU:  r = uz64 ? {64{1'b1}} : uq64;
      div_op_pkg::OP_DIVW:  r = uz32 ? {64{1'b1}} : sign_extend_word(ov32 ? a[31:0] : sq32);
      div_op_pkg::OP_DIVUW: r = uz32 ? {64{1'b1}} : sign_extend_word(uq32);
      div_op_pkg::OP_REM:   r = uz64 ? a : ov64 ? 64'd0 : sr64;
      div_op_pkg::OP_REMU:  r = uz64 ? a : ur64;
      div_op_pkg::OP_REMW:  r = sign_extend_word(uz32 ? a[31:0] : ov32 ? 32'd0 : sr32);
      div_op_pkg::OP_REMUW: r = sign_extend_word(uz32 ? a[31:0] : ur32);
      default:              r = '0;
    endcase
    return r;
  endfunction

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output div_data_pkg::xlen_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // counts rising edges after the accept edge until valid is seen
  task automatic wait_valid(output int lat);
    lat = 0;
    @(negedge clk);
    while (!result_valid_o && lat < VALID_LIMIT) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    if (!result_valid_o) begin
      error_cnt++;
      $display("result_valid_o did not rise within %0d cycles of a start", VALID_LIMIT);
    end
  endtask

  task automatic run_op(input div_op_pkg::div_op_t op, input div_data_pkg::xlen_t a,
                        input div_data_pkg::xlen_t b);
    div_data_pkg::xlen_t expect_v;
    logic                is_w, is_s, exc;
    int                  lat, expect_lat;
    string               tag;
    expect_v = expected_result(op, a, b);
    is_w = op inside {div_op_pkg::OP_DIVW, div_op_pkg::OP_DIVUW,
                      div_op_pkg::OP_REMW, div_op_pkg::OP_REMUW};
    is_s = op inside {div_op_pkg::OP_DIV, div_op_pkg::OP_DIVW,
                      div_op_pkg::OP_REM, div_op_pkg::OP_REMW};
    exc  = is_w ? (b[31:0] == 32'd0) ||
                  (is_s && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
                : (b == 64'd0) ||
                  (is_s && a == 64'h8000_0000_0000_0000 && b == {64{1'b1}});
    expect_lat = exc ? 0 : (is_w ? 33 : 65);             // exceptions skip the iteration
    tag = $sformatf("op %h a %h b %h", op, a, b);
    @(posedge clk);
    start_i    <= 1'b1;
    op_i       <= op;
    dividend_i <= a;
    divisor_i  <= b;
    @(negedge clk);
    check_flag({tag, " busy in accept cycle"}, busy_o, 1'b1);
    @(posedge clk);                                      // accept edge
    start_i <= 1'b0;
    wait_valid(lat);
    check_latency({tag, " latency"}, lat, expect_lat);
    check_result(tag, result_o, expect_v);
    check_flag({tag, " busy with valid"}, busy_o, 1'b0);
    if (is_w) begin
      check_flag({tag, " sign extension"}, result_o[63:32] == {32{result_o[31]}}, 1'b1);
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic test_reset();
    @(negedge clk);
    check_flag("busy after reset", busy_o, 1'b0);
    check_flag("valid after reset", result_valid_o, 1'b0);
    check_result("result after reset", result_o, '0);
  endtask

  task automatic run_pairs(input div_op_pkg::div_op_t op);
    run_op(op, 64'd100, 64'd7);
    run_op(op, -64'sd100, 64'd7);
    run_op(op, 64'd100, -64'sd7);
    run_op(op, -64'sd100, -64'sd7);
    run_op(op, 64'h7fff_ffff_ffff_ffff, 64'd3);
    run_op(op, 64'd7, 64'd100);                          // quotient zero
    run_op(op, 64'h0123_4567_89ab_cdef, 64'hffff_ffff_0000_0013);
  endtask

  task automatic test_all_ops();
    for (int k = 0; k < 8; k++) begin
      run_pairs(8'h80 >> k);
    end
  endtask

  task automatic test_exceptions();
    div_op_pkg::div_op_t op;
    for (int k = 0; k < 8; k++) begin
      op = 8'h80 >> k;
      run_op(op, 64'h1234_5678_9abc_def0, 64'd0);
      run_op(op, 64'h8765_4321_0fed_cba9, 64'hffff_0000_0000_0000); // zero low word
      run_op(op, 64'h8000_0000_0000_0000, {64{1'b1}});
      run_op(op, 64'h5555_5555_8000_0000, 64'h0000_0000_ffff_ffff);
    end
  endtask

  task automatic test_w_upper();
    div_op_pkg::div_op_t w_ops [4];
    w_ops = '{div_op_pkg::OP_DIVUW, div_op_pkg::OP_DIVW,
              div_op_pkg::OP_REMUW, div_op_pkg::OP_REMW};
    for (int k = 0; k < 4; k++) begin
      run_op(w_ops[k], 64'hdead_beef_0000_0064, 64'h1234_5678_ffff_fff9);
      run_op(w_ops[k], 64'h0000_0001_ffff_fff0, 64'hffff_ffff_0000_0001);
    end
  endtask

  task automatic test_backpressure();
    div_data_pkg::xlen_t expect_v;
    int                  lat;
    expect_v = expected_result(div_op_pkg::OP_REM, -64'sd12345, 64'd77);
    @(posedge clk);
    result_ready_i <= 1'b0;
    start_i        <= 1'b1;
    op_i           <= div_op_pkg::OP_REM;
    dividend_i     <= -64'sd12345;
    divisor_i      <= 64'd77;
    @(posedge clk);                                      // accept edge
    start_i <= 1'b0;
    repeat (8) @(posedge clk);
    start_i    <= 1'b1;                                  // must be ignored while busy
    op_i       <= div_op_pkg::OP_DIVU;
    dividend_i <= 64'd99;
    divisor_i  <= 64'd5;
    @(negedge clk);
    check_flag("busy while iterating", busy_o, 1'b1);
    @(posedge clk);
    start_i <= 1'b0;
    wait_valid(lat);
    check_latency("latency with a start while busy", lat + 9, 65);
    repeat (6) begin
      @(posedge clk);
      start_i <= 1'b1;                                   // ignored while finishing
      @(negedge clk);
      check_flag("valid held without ready", result_valid_o, 1'b1);
      check_flag("busy while finishing", busy_o, 1'b0);
      check_result("result held without ready", result_o, expect_v);
    end
    @(posedge clk);
    start_i        <= 1'b0;
    result_ready_i <= 1'b1;
    @(posedge clk);                                      // FINISH to IDLE
    @(negedge clk);
    check_flag("valid after ready", result_valid_o, 1'b0);
    check_flag("busy after ready", busy_o, 1'b0);
    check_result("result after ready", result_o, '0);
  endtask

  task automatic test_random();
    div_data_pkg::xlen_t sel, mode, a, b;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      take_bits(3, sel);
      take_bits(64, a);
      take_bits(64, b);
      take_bits(2, mode);
      if (mode[1:0] == 2'd1) begin
        b = b & 64'hffff;                                // small divisor
      end else if (mode[1:0] == 2'd2) begin
        b = {{56{1'b1}}, b[7:0]};                        // small negative divisor
      end
      run_op(8'h80 >> sel[2:0], a, b);
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    error_cnt      = 0;
    check_cnt      = 0;
    cycle_cnt      = 0;
    lfsr_q         = 32'ha151;
    clk            = 1'b0;
    rst_n          = 1'b1;                               // reset is active high
    start_i        = 1'b0;
    op_i           = div_op_pkg::OP_DIV;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    test_reset();
    test_all_ops();
    test_exceptions();
    test_w_upper();
    test_backpressure();
    test_random();
    $display("%0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_div_unit

`default_nettype wire

// ==== tb.f ====
source/div_op_pkg.sv
source/div_data_pkg.sv
source/div_prep.sv
source/div_core.sv
source/div_post.sv
source/div_unit.sv
verification/tb_div_unit.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
